// ==== entropy_pkg.sv ====
package entropy_pkg;

	//////////////////////////////////////////////////////////////
	// Word formats

	// Width of one entropy word on the stream
	localparam int WORD_BITS = 32;

	// Width of a single sensor reading
	localparam int READING_BITS = 16;

	// User, sensor and jitter
	localparam int NUM_SOURCES = 3;

	// Source tag, doubles as slot index; lower value wins the pick
	typedef enum logic [1:0] {
		SRC_USER   = 2'd0,
		SRC_SENSOR = 2'd1,
		SRC_JITTER = 2'd2
	} source_t;

	// One set of on-die sensor readings, die_temp in the top bits
	typedef struct packed {
		logic [READING_BITS-1:0] die_temp;
		logic [READING_BITS-1:0] volt_core;
		logic [READING_BITS-1:0] volt_ram;
		logic [READING_BITS-1:0] volt_aux;
	} sensor_t;

	// Tagged word as it leaves the collector
	typedef struct packed {
		source_t              source;
		logic [WORD_BITS-1:0] data;
	} entropy_word_t;

	//////////////////////////////////////////////////////////////
	// von Neumann corrector

	// Corrected bits collected per jitter word
	localparam int BITS_PER_WORD = 32;
	localparam int BIT_CNT_BITS  = $clog2(BITS_PER_WORD);

	// Sampling window in clk cycles, two samples per window
	localparam int SAMPLE_CYCLES_DEFAULT = 1024;

endpackage

// ==== link_pkg.sv ====
package link_pkg;

	import entropy_pkg::*;

	//////////////////////////////////////////////////////////////
	// Credit link toward the consumer

	// Counter width, must hold CREDIT_MAX
	localparam int CREDIT_BITS = 3;

	// Credits owned by the sender right after reset
	localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = 3'd4;

	// One beat on the link
	// valid is a single-cycle pulse per word
	typedef struct packed {
		logic          valid;
		entropy_word_t word;
	} link_beat_t;

endpackage

// ==== ring_toggle_sync.sv ====
module ring_toggle_sync (
	input  logic clk_ring,
	input  logic clk,
	input  logic reset,
	output logic toggle_sync
);

	//////////////////////////////////////////////////////////////
	// Ring oscillator side

	// Free-running divide by two of the ring clock
	// Power-up value only, the ring domain sees no reset
	logic toggle_ring = 1'b0;

	always_ff @(posedge clk_ring) begin
		toggle_ring <= !toggle_ring;
	end

	//////////////////////////////////////////////////////////////
	// Crossing into clk

	// Three flops, the first one may go metastable
	logic [2:0] sync_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[1:0], toggle_ring};
		end
	end

	// Edge timing here carries the phase jitter of the two clocks
	assign toggle_sync = sync_q[2];

endmodule

// ==== jitter_corrector.sv ====
module jitter_corrector
	import entropy_pkg::*;
#(
	// Even power of two
	parameter int SAMPLE_CYCLES = SAMPLE_CYCLES_DEFAULT
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 toggle_sync,
	output logic                 jitter_valid,
	output logic [WORD_BITS-1:0] jitter_word
);

	//////////////////////////////////////////////////////////////
	// Sampling window

	// Wraps on its own since SAMPLE_CYCLES is a power of two
	logic [$clog2(SAMPLE_CYCLES)-1:0] window_cnt;

	// Bit 1 holds the first sample, bit 0 the second
	logic [1:0] sample_pair;

	// One corrected bit, ready the cycle after a window start
	logic bit_valid;
	logic bit_value;

	// Kept bits so far in the current word
	logic [BIT_CNT_BITS-1:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			window_cnt  <= '0;
			sample_pair <= '0;
			bit_valid   <= 1'b0;
		end else begin
			window_cnt <= window_cnt + 1'b1;
			bit_valid  <= 1'b0;

			// Window start: judge the last pair, take the first sample
			if (window_cnt == '0) begin
				sample_pair[1] <= toggle_sync;
				// 10 gives a one, 01 a zero, equal pairs are dropped
				if (sample_pair == 2'b10) begin
					bit_valid <= 1'b1;
				end else if (sample_pair == 2'b01) begin
					bit_valid <= 1'b1;
				end
			end

			// Halfway through the window
			if (window_cnt == ($clog2(SAMPLE_CYCLES))'(SAMPLE_CYCLES / 2)) begin
				sample_pair[0] <= toggle_sync;
			end
		end
	end

	// Value only matters together with bit_valid
	always_ff @(posedge clk) begin
		if (window_cnt == '0) begin
			bit_value <= sample_pair[1];
		end
	end

	//////////////////////////////////////////////////////////////
	// Word assembly

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt      <= '0;
			jitter_valid <= 1'b0;
		end else begin
			jitter_valid <= 1'b0;
			if (bit_valid) begin
				bit_cnt <= bit_cnt + 1'b1;
				// Last bit of the word goes in now
				if (bit_cnt == BIT_CNT_BITS'(BITS_PER_WORD - 1)) begin
					jitter_valid <= 1'b1;
				end
			end
		end
	end

	// New bits enter at the LSB
	always_ff @(posedge clk) begin
		if (bit_valid) begin
			jitter_word <= {jitter_word[WORD_BITS-2:0], bit_value};
		end
	end

	// Words are at least a window apart
	a_valid_single: assert property (
		@(posedge clk) disable iff (reset)
		jitter_valid |=> !jitter_valid
	);

endmodule

// ==== entropy_slots.sv ====
module entropy_slots
	import entropy_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,

	// User injection
	input  logic                   entropy_en,
	input  logic [WORD_BITS-1:0]   entropy_data,

	// Sensor readings
	input  logic                   sensors_update,
	input  sensor_t                sensors,

	// Corrected jitter
	input  logic                   jitter_valid,
	input  logic [WORD_BITS-1:0]   jitter_word,

	// From the sender, indexed by source_t
	input  logic [NUM_SOURCES-1:0] take,
	output logic [NUM_SOURCES-1:0] pending,

	output logic [WORD_BITS-1:0]   slot_user,
	output logic [WORD_BITS-1:0]   slot_sensor,
	output logic [WORD_BITS-1:0]   slot_jitter
);

	//////////////////////////////////////////////////////////////
	// Inputs gathered per source

	logic [NUM_SOURCES-1:0]                strobe;
	logic [NUM_SOURCES-1:0][WORD_BITS-1:0] word_in;
	logic [NUM_SOURCES-1:0][WORD_BITS-1:0] slot_q;

	assign strobe[SRC_USER]   = entropy_en;
	assign strobe[SRC_SENSOR] = sensors_update;
	assign strobe[SRC_JITTER] = jitter_valid;

	assign word_in[SRC_USER] = entropy_data;

	// Fold four readings into one word
	assign word_in[SRC_SENSOR] = {
		sensors.die_temp ^ sensors.volt_aux,
		sensors.volt_core ^ sensors.volt_ram
	};

	assign word_in[SRC_JITTER] = jitter_word;

	//////////////////////////////////////////////////////////////
	// One-deep slots

	// Newest word of each source overwrites the older one
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_SOURCES; i++) begin
			if (strobe[i]) begin
				slot_q[i] <= word_in[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			// A fresh word survives a take in the same cycle
			pending <= strobe | (pending & ~take);
		end
	end

	assign slot_user   = slot_q[SRC_USER];
	assign slot_sensor = slot_q[SRC_SENSOR];
	assign slot_jitter = slot_q[SRC_JITTER];

	// Sender only drains slots that hold a word
	a_take_pending: assert property (
		@(posedge clk) disable iff (reset)
		(take & ~pending) == '0
	);

endmodule

// ==== credit_sender.sv ====
module credit_sender
	import entropy_pkg::*;
	import link_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,

	// Slot state
	input  logic [NUM_SOURCES-1:0] pending,
	input  logic [WORD_BITS-1:0]   slot_user,
	input  logic [WORD_BITS-1:0]   slot_sensor,
	input  logic [WORD_BITS-1:0]   slot_jitter,

	// One pulse per credit handed back
	input  logic                   credit_return,

	output logic [NUM_SOURCES-1:0] take,
	output link_beat_t             out_beat
);

	//////////////////////////////////////////////////////////////
	// Priority pick

	logic [CREDIT_BITS-1:0] credit_cnt;
	source_t                pick_src;
	logic [WORD_BITS-1:0]   pick_data;
	logic                   send;

	// User first, then sensor, jitter only when nothing else waits
	always_comb begin
		take      = '0;
		pick_src  = SRC_USER;
		pick_data = slot_user;
		if (credit_cnt != '0) begin
			if (pending[SRC_USER]) begin
				take[SRC_USER] = 1'b1;
			end else if (pending[SRC_SENSOR]) begin
				take[SRC_SENSOR] = 1'b1;
				pick_src         = SRC_SENSOR;
				pick_data        = slot_sensor;
			end else if (pending[SRC_JITTER]) begin
				take[SRC_JITTER] = 1'b1;
				pick_src         = SRC_JITTER;
				pick_data        = slot_jitter;
			end
		end
	end

	assign send = |take;

	//////////////////////////////////////////////////////////////
	// Output beat

	always_ff @(posedge clk) begin
		// Tagged word, don't care while valid is low
		out_beat.word.source <= pick_src;
		out_beat.word.data   <= pick_data;
		if (reset) begin
			out_beat.valid <= 1'b0;
		end else begin
			out_beat.valid <= send;
		end
	end

	//////////////////////////////////////////////////////////////
	// Credit counter

	// A send and a return in one cycle cancel out
	always_ff @(posedge clk) begin
		if (reset) begin
			credit_cnt <= CREDIT_MAX;
		end else begin
			case ({credit_return, send})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Consumer may never give back more than it was sent
	a_credit_max: assert property (
		@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_MAX
	);

	// Each visible beat was paid for on the edge that loaded it
	a_beat_paid: assert property (
		@(posedge clk) disable iff (reset)
		out_beat.valid |-> $past(credit_cnt) != '0
	);

endmodule

// ==== entropy_collector.sv ====
module entropy_collector
	import entropy_pkg::*;
	import link_pkg::*;
#(
	parameter int SAMPLE_CYCLES = SAMPLE_CYCLES_DEFAULT
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 clk_ring,

	input  logic                 entropy_en,
	input  logic [WORD_BITS-1:0] entropy_data,

	input  logic                 sensors_update,
	input  sensor_t              sensors,

	input  logic                 credit_return,
	output link_beat_t           out_beat
);

	logic                   toggle_sync;
	logic                   jitter_valid;
	logic [WORD_BITS-1:0]   jitter_word;
	logic [NUM_SOURCES-1:0] pending;
	logic [NUM_SOURCES-1:0] take;
	logic [WORD_BITS-1:0]   slot_user;
	logic [WORD_BITS-1:0]   slot_sensor;
	logic [WORD_BITS-1:0]   slot_jitter;

	//////////////////////////////////////////////////////////////
	// Jitter source

	ring_toggle_sync u_ring_toggle_sync (
		.clk_ring    (clk_ring),
		.clk         (clk),
		.reset       (reset),
		.toggle_sync (toggle_sync)
	);

	jitter_corrector #(
		.SAMPLE_CYCLES (SAMPLE_CYCLES)
	) u_jitter_corrector (
		.clk          (clk),
		.reset        (reset),
		.toggle_sync  (toggle_sync),
		.jitter_valid (jitter_valid),
		.jitter_word  (jitter_word)
	);

	//////////////////////////////////////////////////////////////
	// Slots and link

	entropy_slots u_entropy_slots (
		.clk            (clk),
		.reset          (reset),
		.entropy_en     (entropy_en),
		.entropy_data   (entropy_data),
		.sensors_update (sensors_update),
		.sensors        (sensors),
		.jitter_valid   (jitter_valid),
		.jitter_word    (jitter_word),
		.take           (take),
		.pending        (pending),
		.slot_user      (slot_user),
		.slot_sensor    (slot_sensor),
		.slot_jitter    (slot_jitter)
	);

	credit_sender u_credit_sender (
		.clk           (clk),
		.reset         (reset),
		.pending       (pending),
		.slot_user     (slot_user),
		.slot_sensor   (slot_sensor),
		.slot_jitter   (slot_jitter),
		.credit_return (credit_return),
		.take          (take),
		.out_beat      (out_beat)
	);

endmodule

// ==== entropy_checker.sv ====
module entropy_checker
	import entropy_pkg::*;
	import link_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 clk_ring,
	input  logic                 entropy_en,
	input  logic [WORD_BITS-1:0] entropy_data,
	input  logic                 sensors_update,
	input  sensor_t              sensors,
	input  logic                 credit_return,
	input  link_beat_t           out_beat,
	output int                   error_count
);

	localparam int SAMPLE_CYCLES = 16;
	localparam int FIRST_JITTER  = BITS_PER_WORD * SAMPLE_CYCLES;

	// Error counter index per checked behavior
	localparam int T_USER     = 0;
	localparam int T_SENSOR   = 1;
	localparam int T_PRIORITY = 2;
	localparam int T_CREDITS  = 3;
	localparam int T_QUIET    = 4;
	localparam int T_RUN      = 5;
	localparam int NUM_TESTS  = 6;

	// Beat expected one edge after the pick
	localparam int KIND_NONE   = 0; // nothing may leave
	localparam int KIND_OPEN   = 1; // a jitter beat or nothing
	localparam int KIND_USER   = 2;
	localparam int KIND_SENSOR = 3;

	int                   errors [NUM_TESTS];
	int                   total;
	int                   credits;
	int                   cycles;
	int                   exp_kind;
	logic [WORD_BITS-1:0] exp_data;
	logic                 exp_multi;
	logic                 user_pending;
	logic                 sensor_pending;
	logic [WORD_BITS-1:0] model_user;
	logic [WORD_BITS-1:0] model_sensor;
	logic                 take_user;
	logic                 take_sensor;
	bit                   jitter_seen;
	bit                   ring_seen;

	assign error_count = total;

	// Ring clock has toggled at least once
	always @(posedge clk_ring) begin
		ring_seen <= 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// Reference rules

	// Upper half die_temp ^ volt_aux, lower half volt_core ^ volt_ram
	function automatic logic [WORD_BITS-1:0] fold_sensors(input sensor_t s);
		return {s.die_temp ^ s.volt_aux, s.volt_core ^ s.volt_ram};
	endfunction

	function automatic string test_name(input int test);
		case (test)
			T_USER:     return "user_word";
			T_SENSOR:   return "sensor_fold";
			T_PRIORITY: return "priority";
			T_CREDITS:  return "credits";
			T_QUIET:    return "jitter_quiet";
			default:    return "jitter_run";
		endcase
	endfunction

	task automatic report_value(input int test, input link_beat_t expected,
			input link_beat_t actual);
		errors[test]++;
		total++;
		$display("** Error %s: expected %h, actual %h at time %0t",
			test_name(test), expected, actual, $time);
	endtask

	task automatic report_text(input int test, input string what);
		errors[test]++;
		total++;
		$display("** Error %s: %s at time %0t", test_name(test), what, $time);
	endtask

	task automatic check_jitter();
		if (!ring_seen) begin
			report_text(T_QUIET, "jitter beat although the ring clock never ran");
		end
		if (!jitter_seen && cycles < FIRST_JITTER) begin
			report_text(T_RUN, "first jitter beat came too soon after reset");
		end
		jitter_seen = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////
	// Beat loaded on the previous edge

	task automatic check_beat();
		link_beat_t exp_beat;
		int         test;
		exp_beat = '0;
		case (exp_kind)
			KIND_NONE: begin
				if (out_beat.valid) begin
					report_text(T_CREDITS, "beat sent while no credit was held");
				end
			end
			KIND_OPEN: begin
				if (out_beat.valid && out_beat.word.source != SRC_JITTER) begin
					report_text(T_PRIORITY, "beat sent with no user or sensor word pending");
				end else if (out_beat.valid) begin
					check_jitter();
				end
			end
			default: begin
				exp_beat.valid = 1'b1;
				exp_beat.word.data = exp_data;
				if (exp_kind == KIND_USER) begin
					exp_beat.word.source = SRC_USER;
					test = T_USER;
				end else begin
					exp_beat.word.source = SRC_SENSOR;
					test = T_SENSOR;
				end
				// Wrong source among several pending is a priority fault
				if (exp_multi && out_beat.valid &&
						out_beat.word.source != exp_beat.word.source) begin
					test = T_PRIORITY;
				end
				if (out_beat !== exp_beat) begin
					report_value(test, exp_beat, out_beat);
				end
			end
		endcase
	endtask

	// Pick from pre-edge state, jitter pending is not visible here
	task automatic predict();
		take_user   = 1'b0;
		take_sensor = 1'b0;
		exp_multi   = user_pending && sensor_pending;
		exp_data    = '0;
		if (credits <= 0) begin
			exp_kind = KIND_NONE;
		end else if (user_pending) begin
			exp_kind  = KIND_USER;
			exp_data  = model_user;
			take_user = 1'b1;
		end else if (sensor_pending) begin
			exp_kind    = KIND_SENSOR;
			exp_data    = model_sensor;
			take_sensor = 1'b1;
		end else begin
			exp_kind = KIND_OPEN;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Model update per clk edge

	always @(posedge clk) begin
		if (reset) begin
			user_pending   = 1'b0;
			sensor_pending = 1'b0;
			credits        = int'(CREDIT_MAX);
			exp_kind       = KIND_NONE;
			cycles         = 0;
			jitter_seen    = 1'b0;
		end else begin
			cycles++;
			check_beat();
			// Visible beat spent its credit on the previous edge
			if (out_beat.valid) begin
				credits--;
			end
			if (credits < 0) begin
				report_text(T_CREDITS, "more beats outstanding than credits");
			end
			predict();
			if (credit_return) begin
				if (credits >= int'(CREDIT_MAX)) begin
					report_text(T_CREDITS, "credit returned with no beat outstanding");
				end else begin
					credits++;
				end
			end
			// A strobe on the take edge keeps the slot pending
			user_pending   = entropy_en || (user_pending && !take_user);
			sensor_pending = sensors_update || (sensor_pending && !take_sensor);
			if (entropy_en) begin
				model_user = entropy_data;
			end
			if (sensors_update) begin
				model_sensor = fold_sensors(sensors);
			end
		end
	end

endmodule

// ==== tb_entropy_collector.sv ====
module tb_entropy_collector
	import entropy_pkg::*;
	import link_pkg::*;
();

	localparam int SAMPLE_CYCLES  = 16;
	localparam int JITTER_TIMEOUT = 40000;

	logic                 clk;
	logic                 reset;
	logic                 clk_ring;
	logic                 entropy_en;
	logic [WORD_BITS-1:0] entropy_data;
	logic                 sensors_update;
	sensor_t              sensors;
	logic                 credit_return;
	link_beat_t           out_beat;
	int                   error_count;

	// Beats seen by the consumer and not yet returned
	int outstanding;
	int beats_seen;
	int jitter_beats;
	int beat_mark;
	int wait_cnt;
	int timeouts;
	bit ring_on;

	entropy_collector #(
		.SAMPLE_CYCLES (SAMPLE_CYCLES)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.clk_ring       (clk_ring),
		.entropy_en     (entropy_en),
		.entropy_data   (entropy_data),
		.sensors_update (sensors_update),
		.sensors        (sensors),
		.credit_return  (credit_return),
		.out_beat       (out_beat)
	);

	entropy_checker u_checker (
		.clk            (clk),
		.reset          (reset),
		.clk_ring       (clk_ring),
		.entropy_en     (entropy_en),
		.entropy_data   (entropy_data),
		.sensors_update (sensors_update),
		.sensors        (sensors),
		.credit_return  (credit_return),
		.out_beat       (out_beat),
		.error_count    (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

	// Ring oscillator with a random half period for the phase jitter
	initial begin
		clk_ring = 1'b0;
		forever begin
			#($urandom_range(11, 3));
			if (ring_on) begin
				clk_ring = !clk_ring;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// One clk cycle of random traffic with rates in percent

	task automatic step(input int user_pct, input int sensor_pct, input int return_pct);
		@(posedge clk);
		if (out_beat.valid) begin
			outstanding++;
			beats_seen++;
			if (out_beat.word.source == SRC_JITTER) begin
				jitter_beats++;
			end
		end
		entropy_en     <= ($urandom_range(99) < user_pct);
		entropy_data   <= $urandom;
		sensors_update <= ($urandom_range(99) < sensor_pct);
		sensors        <= {$urandom, $urandom};
		// Never hand back more than was received
		if (outstanding > 0 && $urandom_range(99) < return_pct) begin
			credit_return <= 1'b1;
			outstanding--;
		end else begin
			credit_return <= 1'b0;
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timeout: %s at time %0t", what, $time);
	endtask

	initial begin
		void'($urandom(32'h88cd_263f));
		reset          = 1'b1;
		entropy_en     = 1'b0;
		entropy_data   = '0;
		sensors_update = 1'b0;
		sensors        = '0;
		credit_return  = 1'b0;
		ring_on        = 1'b0;
		outstanding    = 0;
		beats_seen     = 0;
		jitter_beats   = 0;
		timeouts       = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// User and sensor traffic only while the ring is held still
		repeat (1500) step(25, 20, 60);
		repeat (500) step(60, 60, 15);

		// Spend every credit, then park a user word
		wait_cnt = 0;
		while (outstanding < int'(CREDIT_MAX) && wait_cnt < 100) begin
			step(100, 0, 0);
			wait_cnt++;
		end
		if (outstanding < int'(CREDIT_MAX)) begin
			note_timeout("credits were never used up");
		end
		step(100, 0, 0);
		repeat (30) step(0, 0, 0);

		// One credit back releases the parked word
		beat_mark = beats_seen;
		step(0, 0, 100);
		wait_cnt = 0;
		while (beats_seen == beat_mark && wait_cnt < 10) begin
			step(0, 0, 0);
			wait_cnt++;
		end
		if (beats_seen == beat_mark) begin
			note_timeout("no beat after a credit came back");
		end

		// Second reset with the ring running from its release
		ring_on        = 1'b1;
		reset          <= 1'b1;
		entropy_en     <= 1'b0;
		sensors_update <= 1'b0;
		credit_return  <= 1'b0;
		repeat (8) @(posedge clk);
		outstanding = 0;
		reset <= 1'b0;

		// Light traffic leaves room for jitter words
		beat_mark = jitter_beats;
		wait_cnt  = 0;
		while (jitter_beats == beat_mark && wait_cnt < JITTER_TIMEOUT) begin
			step(2, 2, 60);
			wait_cnt++;
		end
		if (jitter_beats == beat_mark) begin
			note_timeout("no jitter word with the ring clock running");
		end
		repeat (300) step(10, 10, 60);

		$write("Errors: user_word %0d, sensor_fold %0d, priority %0d, credits %0d, ",
			u_checker.errors[0], u_checker.errors[1], u_checker.errors[2],
			u_checker.errors[3]);
		$display("jitter_quiet %0d, jitter_run %0d, timeouts %0d",
			u_checker.errors[4], u_checker.errors[5], timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
entropy_pkg.sv
link_pkg.sv
ring_toggle_sync.sv
jitter_corrector.sv
entropy_slots.sv
credit_sender.sv
entropy_collector.sv
entropy_checker.sv
tb_entropy_collector.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_entropy_collector

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -q "All tests passed"

$(SIM): project.f $(wildcard *.sv)
	verilator --binary --timing --top-module tb_entropy_collector \
		-f project.f -o Vtb_entropy_collector

clean:
	rm -rf obj_dir
